// File: axi_rd_pkg.sv
`include "icache_defines.svh"

package axi_rd_pkg;

    // read address channel
    typedef logic [`AXI_ADDR_W-1:0] axi_addr_t;

    // read data channel
    typedef logic [`AXI_DATA_W-1:0] axi_data_t;

    // transaction id, shared by ar and r
    typedef logic [`AXI_ID_W-1:0]   axi_id_t;

endpackage

// File: cache_way.sv
`include "icache_defines.svh"

module cache_way #(
    parameter int way_id = 0
) (
    input logic        clk,
    cache_array_if.way arr
);
    import icache_pkg::*;

    // storage of one way
    tag_t  tag_mem  [`ICACHE_SETS];
    logic  val_mem  [`ICACHE_SETS];
    line_t line_mem [`ICACHE_SETS];

    // registered read results
    tag_t  tag_q;
    logic  val_q;
    line_t line_q;

    // read every cycle, old content on a same-set write
    always_ff @(posedge clk) begin
        if (arr.tag_wen[way_id]) begin
            tag_mem[arr.index] <= arr.wtag;
        end
        if (arr.val_wen[way_id]) begin
            val_mem[arr.index] <= arr.wvalid;
        end
        if (arr.data_wen[way_id]) begin
            line_mem[arr.index] <= arr.wline;
        end
        tag_q  <= tag_mem[arr.index];
        val_q  <= val_mem[arr.index];
        line_q <= line_mem[arr.index];
    end

    assign arr.tag_back[way_id]   = tag_q;
    assign arr.valid_back[way_id] = val_q;
    assign arr.line_back[way_id]  = line_q;

endmodule

// File: icache.f
+incdir+.
icache_pkg.sv
axi_rd_pkg.sv
icache_if.sv
cache_way.sv
plru_table.sv
refill_unit.sv
icache_ctrl.sv
icache.sv
icache_asserts.sv
icache_tb.sv

// File: icache.sv
`include "icache_defines.svh"

module icache (
    input  logic                   clk,
    input  logic                   rst,
    // processor side
    input  logic                   req,
    input  icache_pkg::set_index_t index,
    input  logic                   offset,
    input  icache_pkg::tag_t       tag,
    output logic                   index_ok,
    output logic                   data_ok,
    output icache_pkg::block_t     rdata,
    // axi read channel
    output axi_rd_pkg::axi_addr_t  araddr,
    output logic                   arvalid,
    input  logic                   arready,
    input  axi_rd_pkg::axi_id_t    rid,
    input  axi_rd_pkg::axi_data_t  rdata_axi,
    input  logic                   rlast,
    input  logic                   rvalid,
    output logic                   rready
);
    import icache_pkg::*;

    way_mask_t  victim;
    set_index_t lookup_index;
    logic       plru_update;

    cache_array_if arr_bus ();
    refill_if      fill_bus ();

    icache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .index        (index),
        .offset       (offset),
        .tag          (tag),
        .index_ok     (index_ok),
        .data_ok      (data_ok),
        .rdata        (rdata),
        .arr          (arr_bus.ctrl),
        .fill         (fill_bus.ctrl),
        .victim       (victim),
        .lookup_index (lookup_index),
        .plru_update  (plru_update)
    );

    refill_unit u_refill (
        .clk       (clk),
        .rst       (rst),
        .fill      (fill_bus.unit),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rid       (rid),
        .rdata_axi (rdata_axi),
        .rlast     (rlast),
        .rvalid    (rvalid),
        .rready    (rready)
    );

    // victim is looked up and updated in the same miss cycle
    plru_table u_plru (
        .clk          (clk),
        .rst          (rst),
        .lookup_index (lookup_index),
        .victim       (victim),
        .update       (plru_update),
        .update_index (lookup_index),
        .update_way   (victim)
    );

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        cache_way #(
            .way_id (w)
        ) u_way (
            .clk (clk),
            .arr (arr_bus.way)
        );
    end

endmodule

// File: icache_asserts.sv
`include "icache_defines.svh"

module icache_asserts (
    input logic                  clk,
    input logic                  rst,
    input logic                  index_ok,
    input logic                  data_ok,
    input logic                  arvalid,
    input logic                  arready,
    input logic                  rready,
    input axi_rd_pkg::axi_addr_t araddr
);

    // number of failed assertions
    int unsigned fail_count = 0;

    // cycles since reset release up to the sweep length
    int unsigned since_rst;

    always_ff @(posedge clk) begin
        if (!rst) begin
            since_rst <= 0;
        end else if (since_rst < `ICACHE_SETS) begin
            since_rst <= since_rst + 1;
        end
    end

    // address request held until accepted
    ar_held: assert property (@(posedge clk) disable iff (!rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else begin
            fail_count++;
            $error("arvalid or araddr changed before arready");
        end

    // burst in flight from arvalid until the last beat
    no_data_in_refill: assert property (@(posedge clk) disable iff (!rst)
        (arvalid || rready) |-> !data_ok)
        else begin
            fail_count++;
            $error("data_ok high while a refill burst was in flight");
        end

    // no requests taken while lines are invalidated
    no_accept_in_sweep: assert property (@(posedge clk) disable iff (!rst)
        (since_rst < `ICACHE_SETS) |-> !index_ok)
        else begin
            fail_count++;
            $error("index_ok high during the reset sweep");
        end

endmodule

bind icache icache_asserts u_asserts (
    .clk      (clk),
    .rst      (rst),
    .index_ok (index_ok),
    .data_ok  (data_ok),
    .arvalid  (arvalid),
    .arready  (arready),
    .rready   (rready),
    .araddr   (araddr)
);

// File: icache_ctrl.sv
`include "icache_defines.svh"

module icache_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req,
    input  icache_pkg::set_index_t index,
    input  logic                   offset,
    input  icache_pkg::tag_t       tag,
    output logic                   index_ok,
    output logic                   data_ok,
    output icache_pkg::block_t     rdata,
    cache_array_if.ctrl            arr,
    refill_if.ctrl                 fill,
    input  icache_pkg::way_mask_t  victim,
    output icache_pkg::set_index_t lookup_index,
    output logic                   plru_update
);
    import icache_pkg::*;
    import axi_rd_pkg::*;

    function automatic block_t pick_half(input line_t line, input logic upper);
        return upper ? line[`ICACHE_LINE_W-1 -: `ICACHE_BLOCK_W]
                     : line[`ICACHE_BLOCK_W-1:0];
    endfunction

    cache_state_e state;
    set_index_t   sweep_cnt;
    way_mask_t    fill_way;

    // tag stage
    logic       sta_valid;
    set_index_t sta_index;
    logic       sta_offset;
    way_mask_t  sta_hit;
    line_t      hit_line;

    // data stage
    logic       sda_valid;
    set_index_t sda_index;
    logic       sda_offset;
    tag_t       sda_tag;
    way_mask_t  sda_hit;
    block_t     sda_block;

    logic sda_free;
    logic sda_miss;

    //////////////////////////////
    // processor handshake
    //////////////////////////////

    assign data_ok  = sda_valid && (state == run) && (|sda_hit);
    assign sda_free = (state == run) && (!sda_valid || data_ok);
    assign sda_miss = (state == run) && sda_valid && !(|sda_hit);
    assign index_ok = req && sda_free;
    assign rdata    = sda_block;

    // tag compare on the arrays read one cycle earlier
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            sta_hit[w] = arr.valid_back[w] && (arr.tag_back[w] == tag);
            if (sta_hit[w]) begin
                hit_line = hit_line | arr.line_back[w];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            sta_valid <= 1'b0;
            sda_valid <= 1'b0;
            sda_hit   <= '0;
        end else begin
            if (index_ok) begin
                sta_valid <= 1'b1;
            end else if (sda_free) begin
                sta_valid <= 1'b0;
            end
            if (sda_free) begin
                sda_valid <= sta_valid;
                sda_hit   <= sta_hit;
            end else if (state == idle) begin
                // missed request now sits in the filled way
                sda_hit <= fill_way;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (index_ok) begin
            sta_index  <= index;
            sta_offset <= offset;
        end
        if (sda_free) begin
            sda_index  <= sta_index;
            sda_offset <= sta_offset;
            sda_tag    <= tag;
            sda_block  <= pick_half(hit_line, sta_offset);
        end else if (state == idle) begin
            sda_block <= pick_half(fill.line, sda_offset);
        end
    end

    //////////////////////////////
    // fsm and reset sweep
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            state     <= reset_sweep;
            sweep_cnt <= '0;
            fill_way  <= '0;
        end else begin
            case (state)
                reset_sweep: begin
                    sweep_cnt <= sweep_cnt + set_index_t'(1);
                    if (sweep_cnt == set_index_t'(`ICACHE_SETS - 1)) begin
                        state <= idle;
                    end
                end
                idle:    state <= run;
                run: begin
                    if (sda_miss) begin
                        state    <= miss;
                        fill_way <= victim;
                    end
                end
                miss:    state <= refill;
                refill:  state <= fill.done ? finish : refill;
                finish:  state <= recover;
                recover: state <= idle;
                default: state <= idle;
            endcase
        end
    end

    assign lookup_index = sda_index;
    assign plru_update  = sda_miss;
    assign fill.start   = (state == miss);
    assign fill.addr    = axi_addr_t'({sda_tag, sda_index, sda_offset, 4'b0000});

    // array port steering
    always_comb begin
        arr.index    = sta_index;
        arr.tag_wen  = '0;
        arr.val_wen  = '0;
        arr.data_wen = '0;
        arr.wvalid   = 1'b1;
        case (state)
            reset_sweep: begin
                arr.index   = sweep_cnt;
                arr.tag_wen = '1;
                arr.val_wen = '1;
                arr.wvalid  = 1'b0;
            end
            finish: begin
                arr.index    = sda_index;
                arr.tag_wen  = fill_way;
                arr.val_wen  = fill_way;
                arr.data_wen = fill_way;
            end
            run:     arr.index = index;
            default: ;
        endcase
    end

    assign arr.wtag  = sda_tag;
    assign arr.wline = fill.line;

endmodule

// File: icache_defines.svh
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

//////////////////////////////
// cache geometry
//////////////////////////////

// four ways, 128 sets of 32-byte lines
`define ICACHE_WAYS     4
`define ICACHE_SETS     128
`define ICACHE_INDEX_W  7
`define ICACHE_TAG_W    20
`define ICACHE_WORDS    8
// half a line goes back per request
`define ICACHE_BLOCK_W  128
`define ICACHE_LINE_W   256

//////////////////////////////
// axi read channel
//////////////////////////////

`define AXI_ADDR_W      32
`define AXI_DATA_W      32
`define AXI_ID_W        4
// read id used for refill bursts
`define ICACHE_RID      0

`endif

// File: icache_if.sv
`include "icache_defines.svh"

//////////////////////////////
// tag/valid/data array port
//////////////////////////////

interface cache_array_if;
    import icache_pkg::*;

    // driven by the controller
    set_index_t index;
    way_mask_t  tag_wen;
    way_mask_t  val_wen;
    tag_t       wtag;
    logic       wvalid;
    way_mask_t  data_wen;
    line_t      wline;

    // each way drives its own slot
    wire tag_t      tag_back  [`ICACHE_WAYS];
    wire way_mask_t valid_back;
    wire line_t     line_back [`ICACHE_WAYS];

    modport ctrl (
        output index, tag_wen, val_wen, wtag, wvalid, data_wen, wline,
        input  tag_back, valid_back, line_back
    );

    modport way (
        input  index, tag_wen, val_wen, wtag, wvalid, data_wen, wline,
        output tag_back, valid_back, line_back
    );
endinterface

//////////////////////////////
// line refill handshake
//////////////////////////////

interface refill_if;
    import icache_pkg::*;
    import axi_rd_pkg::*;

    // start is a single-cycle pulse
    logic      start;
    axi_addr_t addr;
    // line holds from done until the next start
    logic      done;
    line_t     line;

    modport ctrl (output start, addr, input done, line);
    modport unit (input start, addr, output done, line);
endinterface

// File: icache_pkg.sv
`include "icache_defines.svh"

package icache_pkg;

    // physical tag and set number
    typedef logic [`ICACHE_TAG_W-1:0]   tag_t;
    typedef logic [`ICACHE_INDEX_W-1:0] set_index_t;

    // one bit per way, used for selects and hit vectors
    typedef logic [`ICACHE_WAYS-1:0]    way_mask_t;

    // tree pseudo-lru state of one set
    typedef logic [2:0]                 plru_t;

    // payload widths
    typedef logic [`ICACHE_BLOCK_W-1:0] block_t;
    typedef logic [`ICACHE_LINE_W-1:0]  line_t;
    typedef logic [`ICACHE_LINE_W/`ICACHE_WORDS-1:0] word_t;

    // word position inside a line
    typedef logic [$clog2(`ICACHE_WORDS)-1:0] word_ptr_t;

    // controller fsm
    typedef enum logic [2:0] {
        reset_sweep,
        idle,
        run,
        miss,
        refill,
        finish,
        recover
    } cache_state_e;

endpackage

// File: icache_tb.sv
`include "icache_defines.svh"

module icache_tb;
    import icache_pkg::*;
    import axi_rd_pkg::*;

    localparam int clk_period   = 100;
    localparam int reset_cycles = 5;
    localparam int directed_n   = 13;
    localparam int random_n     = 400;
    localparam int total_n      = directed_n + random_n;

    typedef struct packed {
        tag_t       tag;
        set_index_t index;
        logic       offset;
    } fetch_t;

    logic       clk       = 1'b0;
    logic       rst       = 1'b0;
    logic       req       = 1'b0;
    logic       offset    = 1'b0;
    set_index_t index     = '0;
    tag_t       tag       = '0;
    logic       arready   = 1'b0;
    logic       rlast     = 1'b0;
    logic       rvalid    = 1'b0;
    axi_id_t    rid       = '0;
    axi_data_t  rdata_axi = '0;
    logic       index_ok, data_ok, arvalid, rready;
    block_t     rdata;
    axi_addr_t  araddr;

    // reference model results in request order
    fetch_t    stim [$];
    block_t    exp_block [$];
    logic      exp_miss [$];
    axi_addr_t exp_araddr [$];
    tag_t      model_tag [`ICACHE_SETS][`ICACHE_WAYS];
    logic      model_valid [`ICACHE_SETS][`ICACHE_WAYS];
    plru_t     model_plru [`ICACHE_SETS];
    logic      accepted = 1'b0;
    int        ar_count = 0;

    always #(clk_period / 2) clk = ~clk;

    icache uut (.*);

    // request taken at this edge
    always @(posedge clk) begin
        accepted <= req && index_ok;
    end

    //////////////////////////////
    // result checks
    //////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic compare_block(input block_t got, input block_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0t: rdata got %h expected %h", $time, got, exp));
        end
    endtask

    task automatic verify_hit(input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0t: hit got %b expected %b", $time, got, exp));
        end
    endtask

    task automatic match_araddr(input axi_addr_t got, input axi_addr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0t: araddr got %h expected %h", $time, got, exp));
        end
    endtask

    // a failed protocol assertion ends the run at once
    always @(negedge clk) begin
        if (uut.u_asserts.fail_count != 0) begin
            abort_run("a protocol assertion failed");
        end
    end

    //////////////////////////////
    // memory and cache model
    //////////////////////////////

    function automatic axi_data_t mem_word(input axi_addr_t addr);
        return (addr ^ 32'h5A5A_0000) + (addr >> 2);
    endfunction

    // word 0 of the half in the low bits
    function automatic block_t expected_block(input fetch_t f);
        block_t b;
        for (int i = 0; i < 4; i++) begin
            b[i*`AXI_DATA_W +: `AXI_DATA_W] = mem_word({f.tag, f.index, f.offset, 2'(i), 2'b00});
        end
        return b;
    endfunction

    task automatic model_access(input fetch_t f);
        int    way;
        plru_t p;
        way = -1;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (model_valid[f.index][w] && model_tag[f.index][w] == f.tag) begin
                way = w;
            end
        end
        exp_block.push_back(expected_block(f));
        exp_miss.push_back(way < 0);
        if (way < 0) begin
            p = model_plru[f.index];
            // tree walk, then point away from the filled way
            way = !p[0] ? (p[1] ? 1 : 0) : (p[2] ? 3 : 2);
            case (way)
                0:       p[1:0] = 2'b11;
                1:       p[1:0] = 2'b01;
                2:       p[2:0] = {1'b1, p[1], 1'b0};
                default: p[2:0] = {1'b0, p[1], 1'b0};
            endcase
            model_plru[f.index]       = p;
            model_tag[f.index][way]   = f.tag;
            model_valid[f.index][way] = 1'b1;
            exp_araddr.push_back({f.tag, f.index, f.offset, 4'b0000});
        end
    endtask

    task automatic build_stimulus();
        // one line, both halves, then another tag in the same set
        stim.push_back('{20'h12345, 7'd5, 1'b1});
        stim.push_back('{20'h12345, 7'd5, 1'b0});
        stim.push_back('{20'h12345, 7'd5, 1'b1});
        stim.push_back('{20'h54321, 7'd5, 1'b0});
        // six tags into set 9 force evictions
        for (int t = 0; t < 6; t++) begin
            stim.push_back('{tag_t'(20'hA0000 + t), 7'd9, t[0]});
        end
        stim.push_back('{20'hA0000, 7'd9, 1'b0});
        stim.push_back('{20'hA0002, 7'd9, 1'b1});
        stim.push_back('{20'hA0005, 7'd9, 1'b0});
        // small pool of tags and sets so hits and evictions mix
        for (int n = 0; n < random_n; n++) begin
            stim.push_back('{tag_t'(20'h30000 + $urandom % 6), set_index_t'($urandom % 8),
                             1'($urandom % 2)});
        end
    endtask

    // axi memory returning beats in wrap order from the requested word
    initial begin : axi_memory
        axi_addr_t base;
        word_ptr_t ptr;
        int        beats;
        forever begin
            do begin
                @(negedge clk);
                arready = ($urandom % 4) != 0;
                @(posedge clk);
            end while (!(arvalid && arready));
            base = araddr;
            ar_count++;
            if (exp_araddr.size() == 0) begin
                abort_run("the cache sent an address request where no miss was expected");
            end
            match_araddr(base, exp_araddr.pop_front());
            @(negedge clk);
            arready = 1'b0;
            ptr     = base[4:2];
            beats   = 0;
            while (beats < `ICACHE_WORDS) begin
                rvalid    = ($urandom % 3) != 0;
                rid       = axi_id_t'(`ICACHE_RID);
                rdata_axi = mem_word({base[31:5], ptr, 2'b00});
                rlast     = (beats == `ICACHE_WORDS - 1);
                @(posedge clk);
                if (rvalid && rready) begin
                    ptr++;
                    beats++;
                end
                @(negedge clk);
            end
            rvalid = 1'b0;
            rlast  = 1'b0;
        end
    end

    initial begin : watchdog
        #((reset_cycles + `ICACHE_SETS + 20 + total_n * 400) * clk_period);
        abort_run("timeout, the cache stopped answering requests");
    end

    initial begin : stimulus
        fetch_t cur;
        logic   have_cur;
        int     issued;
        int     wait_cycles;
        int     ar_seen;
        int     bursts;
        void'($urandom(50294));
        issued      = 0;
        wait_cycles = 0;
        ar_seen     = 0;
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            model_plru[s] = '0;
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                model_valid[s][w] = 1'b0;
            end
        end
        build_stimulus();
        repeat (reset_cycles) @(negedge clk);
        rst = 1'b1;

        // first request waits out the invalidation sweep
        cur      = stim.pop_front();
        have_cur = 1'b1;
        req      = 1'b1;
        index    = cur.index;
        offset   = cur.offset;
        while (!index_ok) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (wait_cycles < `ICACHE_SETS) begin
            abort_run("index_ok rose before the reset sweep was over");
        end

        while (issued < total_n || exp_block.size() != 0) begin
            @(negedge clk);
            if (data_ok) begin
                if (exp_block.size() == 0) begin
                    abort_run("data_ok came with no request outstanding");
                end
                bursts  = ar_count - ar_seen;
                ar_seen = ar_count;
                if (bursts > 1) begin
                    abort_run("one request caused more than one AXI burst");
                end
                compare_block(rdata, exp_block.pop_front());
                verify_hit(bursts == 0, !exp_miss.pop_front());
            end
            if (accepted) begin
                model_access(cur);
                tag      = cur.tag;
                have_cur = 1'b0;
                issued++;
            end
            // random gaps between requests
            if (!have_cur && stim.size() != 0 && $urandom % 4 != 0) begin
                cur      = stim.pop_front();
                have_cur = 1'b1;
            end
            req    = have_cur;
            index  = cur.index;
            offset = cur.offset;
        end

        repeat (4) @(negedge clk);
        if (ar_count != ar_seen) begin
            abort_run("an AXI burst was started with no response after it");
        end
        if (uut.u_asserts.fail_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            abort_run("a protocol assertion failed during the run");
        end
    end

endmodule

// File: plru_table.sv
`include "icache_defines.svh"

module plru_table (
    input  logic                   clk,
    input  logic                   rst,
    input  icache_pkg::set_index_t lookup_index,
    output icache_pkg::way_mask_t  victim,
    input  logic                   update,
    input  icache_pkg::set_index_t update_index,
    input  icache_pkg::way_mask_t  update_way
);
    import icache_pkg::*;

    plru_t tree [`ICACHE_SETS];
    plru_t cur;

    assign cur = tree[lookup_index];

    // bit 0 picks the pair, bit 1 or bit 2 the way inside it
    always_comb begin
        if (!cur[0]) begin
            victim = cur[1] ? 4'b0010 : 4'b0001;
        end else begin
            victim = cur[2] ? 4'b1000 : 4'b0100;
        end
    end

    // point the tree away from the way just filled
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                tree[s] <= '0;
            end
        end else if (update) begin
            case (update_way)
                4'b0001: tree[update_index][1:0] <= 2'b11;
                4'b0010: tree[update_index][1:0] <= 2'b01;
                4'b0100: begin
                    tree[update_index][2] <= 1'b1;
                    tree[update_index][0] <= 1'b0;
                end
                4'b1000: begin
                    tree[update_index][2] <= 1'b0;
                    tree[update_index][0] <= 1'b0;
                end
                default: ;
            endcase
        end
    end

endmodule

// File: refill_unit.sv
`include "icache_defines.svh"

module refill_unit (
    input  logic                  clk,
    input  logic                  rst,
    refill_if.unit                fill,
    output axi_rd_pkg::axi_addr_t araddr,
    output logic                  arvalid,
    input  logic                  arready,
    input  axi_rd_pkg::axi_id_t   rid,
    input  axi_rd_pkg::axi_data_t rdata_axi,
    input  logic                  rlast,
    input  logic                  rvalid,
    output logic                  rready
);
    import icache_pkg::*;
    import axi_rd_pkg::*;

    axi_addr_t addr_q;
    logic      ar_busy;
    logic      r_busy;
    logic      done_q;
    word_ptr_t ptr;
    word_t     fill_buf [`ICACHE_WORDS];
    line_t     line_w;
    logic      beat;

    // only our own id counts as a beat
    assign beat = r_busy && rvalid && (rid == axi_id_t'(`ICACHE_RID));

    always_ff @(posedge clk) begin
        if (!rst) begin
            ar_busy <= 1'b0;
            r_busy  <= 1'b0;
            done_q  <= 1'b0;
            ptr     <= '0;
        end else begin
            done_q <= beat && rlast;
            if (fill.start) begin
                ar_busy <= 1'b1;
                // wrap burst begins at the requested half
                ptr     <= word_ptr_t'({fill.addr[4], 2'b00});
            end else if (ar_busy && arready) begin
                ar_busy <= 1'b0;
                r_busy  <= 1'b1;
            end else if (beat) begin
                ptr <= ptr + word_ptr_t'(1);
                if (rlast) begin
                    r_busy <= 1'b0;
                end
            end
        end
    end

    // address and beat payload
    always_ff @(posedge clk) begin
        if (fill.start) begin
            addr_q <= fill.addr;
        end
        if (beat) begin
            fill_buf[ptr] <= rdata_axi;
        end
    end

    // word 0 in the low bits
    always_comb begin
        for (int w = 0; w < `ICACHE_WORDS; w++) begin
            line_w[w*$bits(word_t) +: $bits(word_t)] = fill_buf[w];
        end
    end

    assign araddr    = addr_q;
    assign arvalid   = ar_busy;
    assign rready    = r_busy;
    assign fill.done = done_q;
    assign fill.line = line_w;

endmodule
